//--- design/axi_rd_master.sv
`timescale 1ns/100ps
`default_nettype none

module axi_rd_master (
    input  wire                             clk,
    input  wire                             arst_n_i,

    // request / response from the arbiter
    input  wire                             req_valid_i,
    output logic                            req_ready_o,
    input  wire  [rd_bus_pkg::ADDR_W-1:0]   req_addr_i,
    input  rd_bus_pkg::size_e               req_size_i,
    output logic [rd_bus_pkg::DATA_W-1:0]   rsp_data_o,
    output logic                            rsp_valid_o,
    input  wire                             rsp_ready_i,

    // AR channel
    output logic                            arvalid_o,
    input  wire                             arready_i,
    output logic [rd_bus_pkg::ADDR_W-1:0]   araddr_o,
    output rd_bus_pkg::size_e               arsize_o,

    // R channel
    input  wire                             rvalid_i,
    output logic                            rready_o,
    input  wire  [rd_bus_pkg::DATA_W-1:0]   rdata_i
);

    rd_ctrl_pkg::mst_state_e state_q, state_d;

    logic [rd_bus_pkg::ADDR_W-1:0] addr_q;    // latched on acceptance
    rd_bus_pkg::size_e             size_q;
    logic [rd_bus_pkg::DATA_W-1:0] rsp_q;     // aligned response

    logic [2:0]                    off;       // byte offset, aligned to size
    logic [rd_bus_pkg::DATA_W-1:0] shifted;   // beat moved down to bit 0
    logic [rd_bus_pkg::DATA_W-1:0] lanes;     // zero-extended result

    logic req_fire;
    logic r_fire;

    assign req_fire = req_valid_i & req_ready_o;
    assign r_fire   = rvalid_i & rready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            rd_ctrl_pkg::M_IDLE: if (req_fire)    state_d = rd_ctrl_pkg::M_ADDR;
            rd_ctrl_pkg::M_ADDR: if (arready_i)   state_d = rd_ctrl_pkg::M_DATA;
            rd_ctrl_pkg::M_DATA: if (rvalid_i)    state_d = rd_ctrl_pkg::M_RESP;
            rd_ctrl_pkg::M_RESP: if (rsp_ready_i) state_d = rd_ctrl_pkg::M_IDLE;
            default: state_d = rd_ctrl_pkg::M_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rd_ctrl_pkg::M_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // handshake outputs straight off the state
    assign req_ready_o = (state_q == rd_ctrl_pkg::M_IDLE);
    assign arvalid_o   = (state_q == rd_ctrl_pkg::M_ADDR);
    assign rready_o    = (state_q == rd_ctrl_pkg::M_DATA);
    assign rsp_valid_o = (state_q == rd_ctrl_pkg::M_RESP);

    assign araddr_o = addr_q;
    assign arsize_o = size_q;

    // low address bits below the size are dropped
    always_comb begin
        case (size_q)
            rd_bus_pkg::SZ_B: off = addr_q[2:0];
            rd_bus_pkg::SZ_H: off = {addr_q[2:1], 1'b0};
            rd_bus_pkg::SZ_W: off = {addr_q[2], 2'b00};
            default:          off = 3'b000;         // full beat
        endcase

        shifted = rdata_i >> {off, 3'b000};

        case (size_q)
            rd_bus_pkg::SZ_B: lanes = {{(rd_bus_pkg::DATA_W-8){1'b0}}, shifted[7:0]};
            rd_bus_pkg::SZ_H: lanes = {{(rd_bus_pkg::DATA_W-16){1'b0}}, shifted[15:0]};
            rd_bus_pkg::SZ_W: lanes = {{(rd_bus_pkg::DATA_W-32){1'b0}}, shifted[31:0]};
            default:          lanes = shifted;
        endcase
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q <= req_addr_i;
            size_q <= req_size_i;
        end
        if (r_fire) rsp_q <= lanes; // held through M_RESP
    end

    assign rsp_data_o = rsp_q;

endmodule

`default_nettype wire

//--- design/axi_rd_sram.sv
`timescale 1ns/100ps
`default_nettype none

module axi_rd_sram (
    input  wire                                 clk,
    input  wire                                 arst_n_i,

    // AR channel
    input  wire                                 arvalid_i,
    output logic                                arready_o,
    input  wire  [rd_bus_pkg::ADDR_W-1:0]       araddr_i,
    input  rd_bus_pkg::size_e                   arsize_i,   // always a full beat back

    // R channel
    output logic                                rvalid_o,
    input  wire                                 rready_i,
    output logic [rd_bus_pkg::DATA_W-1:0]       rdata_o,

    // image load, one word per cycle
    input  wire                                 load_en_i,
    input  wire  [rd_bus_pkg::WORD_IDX_W-1:0]   load_addr_i,
    input  wire  [rd_bus_pkg::DATA_W-1:0]       load_data_i
);

    rd_ctrl_pkg::sram_state_e state_q, state_d;

    logic [rd_bus_pkg::DATA_W-1:0]     mem [rd_bus_pkg::MEM_WORDS];

    logic [rd_bus_pkg::WORD_IDX_W-1:0] idx_q;      // word being read
    logic [rd_bus_pkg::LAT_CNT_W-1:0]  cnt_q;      // wait cycles left
    logic [rd_bus_pkg::DATA_W-1:0]     rdata_q;

    logic ar_fire;
    logic last_wait;  // array read happens here

    assign ar_fire   = arvalid_i & arready_o;
    assign last_wait = (state_q == rd_ctrl_pkg::S_WAIT) && (cnt_q == 1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            rd_ctrl_pkg::S_IDLE: if (ar_fire)   state_d = rd_ctrl_pkg::S_WAIT;
            rd_ctrl_pkg::S_WAIT: if (last_wait) state_d = rd_ctrl_pkg::S_DATA;
            rd_ctrl_pkg::S_DATA: if (rready_i)  state_d = rd_ctrl_pkg::S_IDLE;
            default: state_d = rd_ctrl_pkg::S_IDLE;
        endcase
    end

    // S_WAIT lasts SRAM_LATENCY-1 cycles, so rvalid lands on the SRAM_LATENCY'th
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rd_ctrl_pkg::S_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (ar_fire) begin
                cnt_q <= rd_bus_pkg::LAT_CNT_W'(rd_bus_pkg::SRAM_LATENCY - 1);
            end else if (state_q == rd_ctrl_pkg::S_WAIT) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // address wraps modulo the array, sub-word bits ignored
    always_ff @(posedge clk) begin
        if (ar_fire) idx_q <= araddr_i[rd_bus_pkg::WORD_IDX_W+2:3];
    end

    // single port array, load and read never overlap
    always_ff @(posedge clk) begin
        if (load_en_i) begin
            mem[load_addr_i] <= load_data_i;
        end
        if (last_wait) rdata_q <= mem[idx_q];
    end

    assign arready_o = (state_q == rd_ctrl_pkg::S_IDLE);
    assign rvalid_o  = (state_q == rd_ctrl_pkg::S_DATA);
    assign rdata_o   = rdata_q; // stable through S_DATA

endmodule

`default_nettype wire

//--- design/rd_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module rd_arbiter (
    input  wire                             clk,
    input  wire                             arst_n_i,

    // load/store side
    input  wire                             mem_r_valid_i,
    output logic                            mem_r_ready_o,
    input  wire  [rd_bus_pkg::ADDR_W-1:0]   mem_r_addr_i,
    input  rd_bus_pkg::size_e               mem_r_size_i,
    output logic [rd_bus_pkg::DATA_W-1:0]   mem_r_data_o,
    output logic                            mem_r_dvalid_o,
    input  wire                             mem_r_dready_i,

    // fetch side
    input  wire                             if_r_valid_i,
    output logic                            if_r_ready_o,
    input  wire  [rd_bus_pkg::ADDR_W-1:0]   if_r_addr_i,
    input  rd_bus_pkg::size_e               if_r_size_i,
    output logic [rd_bus_pkg::DATA_W-1:0]   if_r_data_o,
    output logic                            if_r_dvalid_o,
    input  wire                             if_r_dready_i,

    // towards the read master
    output logic                            s_r_valid_o,
    input  wire                             s_r_ready_i,
    output logic [rd_bus_pkg::ADDR_W-1:0]   s_r_addr_o,
    output rd_bus_pkg::size_e               s_r_size_o,
    input  wire  [rd_bus_pkg::DATA_W-1:0]   s_r_data_i,
    input  wire                             s_r_dvalid_i,
    output logic                            s_r_dready_o
);

    rd_ctrl_pkg::arb_state_e state_q, state_d;

    logic mem_sel;   // grant held by load/store
    logic if_sel;    // grant held by fetch
    logic rsp_done;  // response handshake on the granted side

    assign mem_sel = (state_q == rd_ctrl_pkg::ARB_MEM);
    assign if_sel  = (state_q == rd_ctrl_pkg::ARB_IF);

    assign rsp_done = s_r_dvalid_i & s_r_dready_o;

    // grant only taken from idle, mem has priority
    always_comb begin
        state_d = state_q;
        case (state_q)
            rd_ctrl_pkg::ARB_IDLE: begin
                if (mem_r_valid_i) begin
                    state_d = rd_ctrl_pkg::ARB_MEM;
                end else if (if_r_valid_i) begin
                    state_d = rd_ctrl_pkg::ARB_IF;
                end
            end
            rd_ctrl_pkg::ARB_MEM,
            rd_ctrl_pkg::ARB_IF: begin
                if (rsp_done) state_d = rd_ctrl_pkg::ARB_IDLE; // released on accepted data
            end
            default: state_d = rd_ctrl_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rd_ctrl_pkg::ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request path, nothing reaches the master without a grant
    assign s_r_valid_o  = (mem_sel & mem_r_valid_i) | (if_sel & if_r_valid_i);
    assign s_r_addr_o   = mem_sel ? mem_r_addr_i : if_r_addr_i;
    assign s_r_size_o   = mem_sel ? mem_r_size_i : if_r_size_i;
    assign s_r_dready_o = (mem_sel & mem_r_dready_i) | (if_sel & if_r_dready_i);

    // handshakes back only to the owner
    assign mem_r_ready_o  = mem_sel & s_r_ready_i;
    assign if_r_ready_o   = if_sel & s_r_ready_i;
    assign mem_r_dvalid_o = mem_sel & s_r_dvalid_i;
    assign if_r_dvalid_o  = if_sel & s_r_dvalid_i;

    // data broadcast, dvalid qualifies it
    assign mem_r_data_o = s_r_data_i;
    assign if_r_data_o  = s_r_data_i;

endmodule

`default_nettype wire

//--- design/rd_bus_pkg.sv
`default_nettype none

package rd_bus_pkg;

    // byte address as seen by both requesters
    localparam int ADDR_W = 32;

    // one beat on the R channel
    localparam int DATA_W = 64;

    // sram geometry, one entry per 64-bit beat
    localparam int MEM_WORDS  = 256;
    localparam int WORD_IDX_W = 8;     // log2(MEM_WORDS)

    // cycles from AR transfer to rvalid
    localparam int SRAM_LATENCY = 3;
    localparam int LAT_CNT_W    = $clog2(SRAM_LATENCY + 1); // wait counter width

    // access size, same code as AXI arsize
    typedef enum logic [1:0] {
        SZ_B = 2'd0,   // 1 byte
        SZ_H = 2'd1,   // 2 bytes
        SZ_W = 2'd2,   // 4 bytes
        SZ_D = 2'd3    // full beat
    } size_e;

endpackage

`default_nettype wire

//--- design/rd_ctrl_pkg.sv
`default_nettype none

package rd_ctrl_pkg;

    // who owns the shared read channel
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_MEM  = 2'd1,
        ARB_IF   = 2'd2
    } arb_state_e;

    // read master sequence
    typedef enum logic [1:0] {
        M_IDLE = 2'd0,   // waiting for a request
        M_ADDR = 2'd1,   // AR valid
        M_DATA = 2'd2,   // R ready
        M_RESP = 2'd3    // response held for the requester
    } mst_state_e;

    // sram slave sequence
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_WAIT = 2'd1,
        S_DATA = 2'd2
    } sram_state_e;

endpackage

`default_nettype wire

//--- design/rd_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module rd_subsys_top (
    input  wire                                 clk,
    input  wire                                 arst_n_i,

    // load/store requester
    input  wire                                 mem_r_valid_i,
    output logic                                mem_r_ready_o,
    input  wire  [rd_bus_pkg::ADDR_W-1:0]       mem_r_addr_i,
    input  rd_bus_pkg::size_e                   mem_r_size_i,
    output logic [rd_bus_pkg::DATA_W-1:0]       mem_r_data_o,
    output logic                                mem_r_dvalid_o,
    input  wire                                 mem_r_dready_i,

    // fetch requester
    input  wire                                 if_r_valid_i,
    output logic                                if_r_ready_o,
    input  wire  [rd_bus_pkg::ADDR_W-1:0]       if_r_addr_i,
    input  rd_bus_pkg::size_e                   if_r_size_i,
    output logic [rd_bus_pkg::DATA_W-1:0]       if_r_data_o,
    output logic                                if_r_dvalid_o,
    input  wire                                 if_r_dready_i,

    // sram image load
    input  wire                                 load_en_i,
    input  wire  [rd_bus_pkg::WORD_IDX_W-1:0]   load_addr_i,
    input  wire  [rd_bus_pkg::DATA_W-1:0]       load_data_i
);

    // arbiter <-> master
    logic                          s_r_valid;
    logic                          s_r_ready;
    logic [rd_bus_pkg::ADDR_W-1:0] s_r_addr;
    rd_bus_pkg::size_e             s_r_size;
    logic [rd_bus_pkg::DATA_W-1:0] s_r_data;
    logic                          s_r_dvalid;
    logic                          s_r_dready;

    // master <-> sram
    logic                          arvalid;
    logic                          arready;
    logic [rd_bus_pkg::ADDR_W-1:0] araddr;
    rd_bus_pkg::size_e             arsize;
    logic                          rvalid;
    logic                          rready;
    logic [rd_bus_pkg::DATA_W-1:0] rdata;

    rd_arbiter u_arbiter (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_ready_o  (mem_r_ready_o),
        .mem_r_addr_i   (mem_r_addr_i),
        .mem_r_size_i   (mem_r_size_i),
        .mem_r_data_o   (mem_r_data_o),
        .mem_r_dvalid_o (mem_r_dvalid_o),
        .mem_r_dready_i (mem_r_dready_i),
        .if_r_valid_i   (if_r_valid_i),
        .if_r_ready_o   (if_r_ready_o),
        .if_r_addr_i    (if_r_addr_i),
        .if_r_size_i    (if_r_size_i),
        .if_r_data_o    (if_r_data_o),
        .if_r_dvalid_o  (if_r_dvalid_o),
        .if_r_dready_i  (if_r_dready_i),
        .s_r_valid_o    (s_r_valid),
        .s_r_ready_i    (s_r_ready),
        .s_r_addr_o     (s_r_addr),
        .s_r_size_o     (s_r_size),
        .s_r_data_i     (s_r_data),
        .s_r_dvalid_i   (s_r_dvalid),
        .s_r_dready_o   (s_r_dready)
    );

    axi_rd_master u_master (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (s_r_valid),
        .req_ready_o (s_r_ready),
        .req_addr_i  (s_r_addr),
        .req_size_i  (s_r_size),
        .rsp_data_o  (s_r_data),
        .rsp_valid_o (s_r_dvalid),
        .rsp_ready_i (s_r_dready),
        .arvalid_o   (arvalid),
        .arready_i   (arready),
        .araddr_o    (araddr),
        .arsize_o    (arsize),
        .rvalid_i    (rvalid),
        .rready_o    (rready),
        .rdata_i     (rdata)
    );

    axi_rd_sram u_sram (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .arvalid_i   (arvalid),
        .arready_o   (arready),
        .araddr_i    (araddr),
        .arsize_i    (arsize),
        .rvalid_o    (rvalid),
        .rready_i    (rready),
        .rdata_o     (rdata),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i)
    );

endmodule

`default_nettype wire

//--- rd_subsys_top.f
design/rd_bus_pkg.sv
design/rd_ctrl_pkg.sv
design/rd_arbiter.sv
design/axi_rd_master.sv
design/axi_rd_sram.sv
design/rd_subsys_top.sv
testbench/tb_rd_subsys.sv

//--- testbench/tb_rd_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rd_subsys;

    localparam int LIMIT = 1000;  // cycles any one wait may take
    localparam int MIX_N = 200;

    logic                                  clk;
    logic                                  arst_n_i;
    logic                                  mem_r_valid_i;
    logic                                  mem_r_ready_o;
    logic [rd_bus_pkg::ADDR_W-1:0]         mem_r_addr_i;
    rd_bus_pkg::size_e                     mem_r_size_i;
    logic [rd_bus_pkg::DATA_W-1:0]         mem_r_data_o;
    logic                                  mem_r_dvalid_o;
    logic                                  mem_r_dready_i;
    logic                                  if_r_valid_i;
    logic                                  if_r_ready_o;
    logic [rd_bus_pkg::ADDR_W-1:0]         if_r_addr_i;
    rd_bus_pkg::size_e                     if_r_size_i;
    logic [rd_bus_pkg::DATA_W-1:0]         if_r_data_o;
    logic                                  if_r_dvalid_o;
    logic                                  if_r_dready_i;
    logic                                  load_en_i;
    logic [rd_bus_pkg::WORD_IDX_W-1:0]     load_addr_i;
    logic [rd_bus_pkg::DATA_W-1:0]         load_data_i;

    logic [rd_bus_pkg::DATA_W-1:0] ref_mem [rd_bus_pkg::MEM_WORDS];  // expected sram image
    logic [63:0] rng_state;

    rd_subsys_top DUT (.*);

    always #20 clk = ~clk;  // 40 ns period

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function logic [63:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // word picked by address, lanes from the size-aligned offset, zero-extended
    function automatic logic [63:0] expected_read(input logic [31:0] addr,
                                                  input rd_bus_pkg::size_e size);
        logic [63:0] word;
        int          nbytes;
        int          off;
        nbytes = 1 << size;
        off    = addr % 8;
        off    = off - (off % nbytes);  // drop bits below the size
        word   = ref_mem[(addr / 8) % rd_bus_pkg::MEM_WORDS];
        word   = word >> (8 * off);
        if (nbytes < 8) word = word & ((64'd1 << (8 * nbytes)) - 1);
        return word;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string test, input string what,
                            input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("ERROR %s: %s expected %h actual %h",
                                     test, what, exp, act));
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_mem(input string test, input logic [31:0] addr,
                            input rd_bus_pkg::size_e size);
        int waited;
        waited        = 0;
        mem_r_valid_i = 1'b1;
        mem_r_addr_i  = addr;
        mem_r_size_i  = size;
        while (!mem_r_ready_o) begin  // ready only depends on state
            @(negedge clk);
            waited++;
            if (waited > LIMIT) report_failure({"timeout in ", test, ": mem request not accepted"});
        end
        @(negedge clk);               // transfer on the edge in between
        mem_r_valid_i = 1'b0;
    endtask

    task automatic send_if(input string test, input logic [31:0] addr,
                           input rd_bus_pkg::size_e size);
        int waited;
        waited       = 0;
        if_r_valid_i = 1'b1;
        if_r_addr_i  = addr;
        if_r_size_i  = size;
        while (!if_r_ready_o) begin
            @(negedge clk);
            waited++;
            if (waited > LIMIT) report_failure({"timeout in ", test, ": if request not accepted"});
        end
        @(negedge clk);
        if_r_valid_i = 1'b0;
    endtask

    task automatic take_mem_rsp(input string test, input logic [63:0] exp);
        int waited;
        waited         = 0;
        mem_r_dready_i = 1'b1;
        while (!mem_r_dvalid_o) begin
            @(negedge clk);
            waited++;
            if (waited > LIMIT) report_failure({"timeout in ", test, ": no mem response"});
        end
        check_eq(test, "mem data", exp, mem_r_data_o);
        @(negedge clk);
        mem_r_dready_i = 1'b0;
    endtask

    task automatic take_if_rsp(input string test, input logic [63:0] exp);
        int waited;
        waited        = 0;
        if_r_dready_i = 1'b1;
        while (!if_r_dvalid_o) begin
            @(negedge clk);
            waited++;
            if (waited > LIMIT) report_failure({"timeout in ", test, ": no if response"});
        end
        check_eq(test, "if data", exp, if_r_data_o);
        @(negedge clk);
        if_r_dready_i = 1'b0;
    endtask

    task automatic load_image();
        for (int i = 0; i < rd_bus_pkg::MEM_WORDS; i++) begin
            load_en_i   = 1'b1;
            load_addr_i = rd_bus_pkg::WORD_IDX_W'(i);
            load_data_i = ref_mem[i];
            @(negedge clk);
        end
        load_en_i = 1'b0;
    endtask

    task automatic test_reset_idle();
        repeat (20) begin
            @(negedge clk);
            check_eq("reset_idle", "mem ready", 0, mem_r_ready_o);
            check_eq("reset_idle", "if ready", 0, if_r_ready_o);
            check_eq("reset_idle", "mem dvalid", 0, mem_r_dvalid_o);
            check_eq("reset_idle", "if dvalid", 0, if_r_dvalid_o);
        end
    endtask

    task automatic test_if_sizes();
        logic [31:0]       addr;
        rd_bus_pkg::size_e size;
        for (int i = 0; i < 16; i++) begin
            addr = 32'(next_rand());
            size = rd_bus_pkg::size_e'(i % 4);  // every size four times
            send_if("if_sizes", addr, size);
            take_if_rsp("if_sizes", expected_read(addr, size));
        end
    endtask

    task automatic test_mem_sizes();
        logic [31:0]       addr;
        rd_bus_pkg::size_e size;
        for (int i = 0; i < 18; i++) begin
            addr = 32'(next_rand());
            if (i == 0) addr = 32'h0000_0805;  // one past the top, back to word 0
            if (i == 1) addr = 32'h0001_07fe;  // last word, high half
            size = rd_bus_pkg::size_e'(i % 4);
            send_mem("mem_sizes", addr, size);
            take_mem_rsp("mem_sizes", expected_read(addr, size));
        end
    endtask

    task automatic test_priority();
        logic [31:0] a_mem;
        logic [31:0] a_if;
        time         t_mem_acc;
        time         t_if_acc;
        time         t_mem_rsp;
        time         t_if_rsp;
        a_mem = 32'(next_rand());
        a_if  = 32'(next_rand());
        fork  // both valids rise on the same edge
            begin
                send_mem("priority", a_mem, rd_bus_pkg::SZ_W);
                t_mem_acc = $time;
                take_mem_rsp("priority", expected_read(a_mem, rd_bus_pkg::SZ_W));
                t_mem_rsp = $time;
            end
            begin
                send_if("priority", a_if, rd_bus_pkg::SZ_D);
                t_if_acc = $time;
                take_if_rsp("priority", expected_read(a_if, rd_bus_pkg::SZ_D));
                t_if_rsp = $time;
            end
        join
        check_eq("priority", "mem accepted first", 1, t_mem_acc < t_if_acc);
        check_eq("priority", "mem response first", 1, t_mem_rsp < t_if_rsp);
    endtask

    task automatic test_backpressure();
        logic [31:0] a_mem;
        logic [31:0] a_if;
        logic [63:0] held;
        int          hold;
        int          waited;
        a_mem  = 32'(next_rand());
        a_if   = 32'(next_rand());
        hold   = 5 + int'(next_rand() % 11);
        waited = 0;
        send_mem("backpressure", a_mem, rd_bus_pkg::SZ_H);
        while (!mem_r_dvalid_o) begin  // dready kept low
            @(negedge clk);
            waited++;
            if (waited > LIMIT) report_failure("timeout in backpressure: no mem response");
        end
        held = mem_r_data_o;
        check_eq("backpressure", "mem data", expected_read(a_mem, rd_bus_pkg::SZ_H), held);
        if_r_valid_i = 1'b1;  // fetch now pending behind mem
        if_r_addr_i  = a_if;
        if_r_size_i  = rd_bus_pkg::SZ_B;
        repeat (hold) begin
            @(negedge clk);
            check_eq("backpressure", "mem dvalid held", 1, mem_r_dvalid_o);
            check_eq("backpressure", "mem data held", held, mem_r_data_o);
            check_eq("backpressure", "if ready", 0, if_r_ready_o);
        end
        mem_r_dready_i = 1'b1;
        @(negedge clk);
        mem_r_dready_i = 1'b0;
        check_eq("backpressure", "mem dvalid after release", 0, mem_r_dvalid_o);
        send_if("backpressure", a_if, rd_bus_pkg::SZ_B);
        take_if_rsp("backpressure", expected_read(a_if, rd_bus_pkg::SZ_B));
    endtask

    task automatic test_random_mix();
        logic              mix_port [MIX_N];  // 0 mem, 1 if
        logic [31:0]       mix_addr [MIX_N];
        rd_bus_pkg::size_e mix_size [MIX_N];
        int                mix_gap  [MIX_N];
        for (int i = 0; i < MIX_N; i++) begin
            mix_port[i] = next_rand() % 2;
            mix_addr[i] = 32'(next_rand());
            mix_size[i] = rd_bus_pkg::size_e'(next_rand() % 4);
            mix_gap[i]  = int'(next_rand() % 3);  // short idle so if is not starved
        end
        // one read in flight per port, each response matched to its own request
        fork
            for (int i = 0; i < MIX_N; i++) begin
                if (mix_port[i] == 1'b0) begin
                    repeat (mix_gap[i]) @(negedge clk);
                    send_mem("random_mix", mix_addr[i], mix_size[i]);
                    take_mem_rsp("random_mix", expected_read(mix_addr[i], mix_size[i]));
                end
            end
            for (int i = 0; i < MIX_N; i++) begin
                if (mix_port[i] == 1'b1) begin
                    repeat (mix_gap[i]) @(negedge clk);
                    send_if("random_mix", mix_addr[i], mix_size[i]);
                    take_if_rsp("random_mix", expected_read(mix_addr[i], mix_size[i]));
                end
            end
        join
    endtask

    initial begin
        clk            = 1'b0;
        arst_n_i       = 1'b0;
        mem_r_valid_i  = 1'b0;
        mem_r_addr_i   = '0;
        mem_r_size_i   = rd_bus_pkg::SZ_B;
        mem_r_dready_i = 1'b0;
        if_r_valid_i   = 1'b0;
        if_r_addr_i    = '0;
        if_r_size_i    = rd_bus_pkg::SZ_B;
        if_r_dready_i  = 1'b0;
        load_en_i      = 1'b0;
        load_addr_i    = '0;
        load_data_i    = '0;
        rng_state      = 64'd97575;
        for (int i = 0; i < rd_bus_pkg::MEM_WORDS; i++) ref_mem[i] = next_rand();
        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        load_image();
        test_reset_idle();
        test_if_sizes();
        test_mem_sizes();
        test_priority();
        test_backpressure();
        test_random_mix();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
